//--- tb.f
+incdir+tb
common/capture_pkg.sv
capture/ref_timing.sv
capture/phase_tracker.sv
capture/sample_picker.sv
source/capture_ctrl.sv
source/capture_top.sv
tb/tb_capture_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the capture testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   -f tb.f --top-module tb_capture_top -j 0

# The simulator exits nonzero on a fatal error, keep its output for the search
output=$(./obj_dir/Vtb_capture_top 2>&1 || true)
echo "$output"

if grep -qF "Done: no errors" <<< "$output"; then
   echo "PASS"
else
   echo "FAIL"
   exit 1
fi

//--- tb/tb_tasks.svh
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

// --------------------
// Failure and compare
// --------------------
task automatic stop_on_error(input string what);
   $display("%s", what);
   $display("Done: errors found");
   $fatal(1, "Simulation stopped at first error");
endtask

task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] want);
   if (got !== want) begin
      stop_on_error($sformatf("MISMATCH at %0t ns: %s got 0x%0h, expected 0x%0h",
                              $time, name, got, want));
   end
endtask

// --------------------
// AXI4-Lite master
// --------------------
task automatic axil_write(input logic [7:0] addr, input logic [31:0] data,
                          output logic [1:0] resp);
   @(posedge clk_s);
   #2;
   axil_req.awaddr  = addr;
   axil_req.awvalid = 1'b1;
   axil_req.wdata   = data;
   axil_req.wstrb   = '1;
   axil_req.wvalid  = 1'b1;
   axil_req.bready  = 1'b1;
   @(negedge clk_s);
   while (!axil_rsp.awready) begin
      @(negedge clk_s);
   end
   check_eq("wready", axil_rsp.wready, 1'b1);  // Raised together with awready
   @(posedge clk_s);                   // AW and W taken on this edge
   #2;
   axil_req.awvalid = 1'b0;
   axil_req.wvalid  = 1'b0;
   @(negedge clk_s);
   while (!axil_rsp.bvalid) begin
      @(negedge clk_s);
   end
   resp = axil_rsp.bresp;
   @(posedge clk_s);                   // B taken
   #2;
   axil_req.bready = 1'b0;
endtask

task automatic axil_read(input logic [7:0] addr, output logic [31:0] data,
                         output logic [1:0] resp);
   @(posedge clk_s);
   #2;
   axil_req.araddr  = addr;
   axil_req.arvalid = 1'b1;
   axil_req.rready  = 1'b1;
   @(negedge clk_s);
   while (!axil_rsp.arready) begin
      @(negedge clk_s);
   end
   @(posedge clk_s);
   #2;
   axil_req.arvalid = 1'b0;
   @(negedge clk_s);
   while (!axil_rsp.rvalid) begin
      @(negedge clk_s);
   end
   data = axil_rsp.rdata;
   resp = axil_rsp.rresp;
   @(posedge clk_s);
   #2;
   axil_req.rready = 1'b0;
endtask

// Mapped register access that expects an OKAY response
task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
   logic [1:0] resp;
   axil_write(addr, data, resp);
   check_eq($sformatf("bresp @0x%02h", addr), resp, RESP_OKAY);
endtask

task automatic read_reg(input logic [7:0] addr, output logic [31:0] data);
   logic [1:0] resp;
   axil_read(addr, data, resp);
   check_eq($sformatf("rresp @0x%02h", addr), resp, RESP_OKAY);
endtask

// Re-read status once per period until it matches or the budget runs out
task automatic poll_status(input logic [31:0] want, input int polls);
   logic [31:0] d;
   int          n;
   n = 0;
   read_reg(REG_STATUS, d);
   while (d !== want && n < polls) begin
      repeat (RATIO) @(posedge clk_s);
      read_reg(REG_STATUS, d);
      n++;
   end
   check_eq("REG_STATUS", d, want);
endtask

// --------------------
// Stimulus helpers
// --------------------
// Moves a channel's bit boundaries later by d half-cycles without a stray edge
task automatic shift_offset(input int ch, input int d);
   int r;
   r = -1;
   while (r < d || r > SPAN - 2) begin
      @(posedge clk_s);
      #1;                              // Ahead of the drive at 2 ns
      r = (2 * cyc - off[ch]) % SPAN;
   end
   off[ch] = off[ch] + d;
endtask

task automatic collect_words(input int n);
   int got;
   got = 0;
   while (got < n) begin
      @(negedge clk_s);
      if (sample_valid) begin
         words[got]  = sample;
         word_h[got] = 2 * (cyc - 1);  // Pair on the pins right now
         if (got > 0) begin
            // One word per reference period
            check_eq("sample_valid_o spacing", word_h[got] - word_h[got - 1], SPAN);
         end
         got++;
      end
   end
endtask

// Bit that lies s bits before the one on the pins at half-slot h
function automatic logic picked_bit(input int ch, input int h, input int s);
   int k;
   k = (h - off[ch]) / SPAN - s;
   return (k < 0) ? 1'b0 : bits[ch][k];
endfunction

// --------------------
// Directed tests
// --------------------
task automatic test_registers();
   logic [31:0] d;
   logic [1:0]  resp;
   write_reg(REG_CTRL, 32'h7);         // Enable, invert, retry
   read_reg(REG_CTRL, d);
   check_eq("REG_CTRL", d, 32'h3);     // Retry never reads back
   axil_read(8'h40, d, resp);
   check_eq("rresp unmapped", resp, RESP_SLVERR);
   check_eq("rdata unmapped", d, 32'h0);
   axil_write(8'h44, 32'h1, resp);
   check_eq("bresp unmapped", resp, RESP_SLVERR);
   read_reg(REG_CTRL, d);
   check_eq("REG_CTRL after unmapped write", d, 32'h3);
endtask

task automatic test_lock();
   write_reg(REG_CTRL, 32'h1);         // Enable, rising reference edge
   repeat ((COUNT + 2) * RATIO) @(posedge clk_s);
   poll_status(ALL_LOCKED, LOCK_POLLS);
endtask

task automatic test_phase();
   logic [31:0] d;
   int          ph [NCHAN];
   for (int i = 0; i < NCHAN; i++) begin
      read_reg(REG_PHASE0 + 8'(4 * i), d);
      ph[i] = int'(d);
   end
   // Reference latency cancels in the difference
   for (int i = 1; i < NCHAN; i++) begin
      check_eq($sformatf("phase ch%0d minus ch0", i), (ph[i] - ph[0] + SPAN) % SPAN,
               (off[i] - off[0] + SPAN) % SPAN);
   end
endtask

task automatic test_lock_loss();
   shift_offset(1, LIMIT + 2);
   poll_status((32'h2 << 8) | (ALL_LOCKED & ~32'h2), LOCK_POLLS);
   write_reg(REG_CTRL, 32'h5);         // Retry pulse with enable kept
   repeat ((COUNT + 2) * RATIO) @(posedge clk_s);
   poll_status(ALL_LOCKED, LOCK_POLLS);
endtask

task automatic test_stream();
   int best_s;
   int best_n;
   int hits;
   collect_words(NWORDS);
   for (int ch = 0; ch < NCHAN; ch++) begin
      best_s = 0;
      best_n = -1;
      for (int s = 0; s < 4; s++) begin  // Up to four periods back
         hits = 0;
         for (int w = 0; w < NWORDS; w++) begin
            if (words[w][ch] === picked_bit(ch, word_h[w], s)) begin
               hits++;
            end
         end
         if (hits > best_n) begin
            best_n = hits;
            best_s = s;
         end
      end
      for (int w = 0; w < NWORDS; w++) begin
         check_eq($sformatf("sample_o[%0d] word %0d", ch, w), words[w][ch],
                  picked_bit(ch, word_h[w], best_s));
      end
   end
endtask

task automatic test_disable();
   logic [31:0] d;
   write_reg(REG_CTRL, 32'h0);
   read_reg(REG_STATUS, d);
   check_eq("REG_STATUS disabled", d, 32'h0);
   collect_words(4);
   for (int w = 0; w < 4; w++) begin
      check_eq($sformatf("sample_o disabled word %0d", w), words[w], 32'h0);
   end
endtask

`endif

//--- tb/tb_capture_top.sv
`timescale 1ns/10ps

module tb_capture_top
   import capture_pkg::*;
();

   localparam int NCHAN  = 4;
   localparam int RATIO  = 6;
   localparam int RBITS  = 3;
   localparam int LIMIT  = 2;
   localparam int COUNT  = 7;
   localparam int TICKS  = 2;
   localparam int SPAN   = 2 * RATIO;    // Half-cycles per antenna bit
   localparam int SEED   = 7;
   localparam int NBITS  = 1024;         // Bits per channel, longer than any run
   localparam int NWORDS = 24;           // Words taken for the stream check

   // --------------------
   // Test lengths in clocks
   // --------------------
   localparam int POLL_CLKS  = RATIO + 8;            // One wait plus one status read
   localparam int LOCK_POLLS = 6 * COUNT;
   localparam int T_REGS     = 60;
   localparam int T_LOCK     = (COUNT + 2) * RATIO + LOCK_POLLS * POLL_CLKS;
   localparam int T_PHASE    = NCHAN * 10;
   localparam int T_LOSS     = SPAN + LOCK_POLLS * POLL_CLKS + T_LOCK;
   localparam int T_STREAM   = (NWORDS + 2) * RATIO;
   localparam int T_OFF      = 30 + 6 * RATIO;
   localparam int MAX_CYCLES = 2 * (T_REGS + T_LOCK + T_PHASE + T_LOSS + T_STREAM + T_OFF);

   localparam logic [31:0] ALL_LOCKED = (1 << NCHAN) - 1;

   logic                  clk_s;
   logic                  reset;
   logic                  ref_clk;     // Reference clock as a level
   ddr_pair_t [NCHAN-1:0] sig;
   axil_req_t             axil_req;
   axil_rsp_t             axil_rsp;
   logic      [NCHAN-1:0] sample;
   logic                  sample_valid;

   logic             bits   [NCHAN][NBITS];   // Random antenna data
   int               off    [NCHAN] = '{0, 3, 7, 10};  // Per-channel shift, half-cycles
   int               cyc;                     // Clock index of the next drive
   int               cycles;
   logic [NCHAN-1:0] words  [NWORDS];         // Captured sample words
   int               word_h [NWORDS];         // Half-slot being driven at each word

   capture_top #(
      .NCHAN (NCHAN),
      .RATIO (RATIO),
      .RBITS (RBITS),
      .LIMIT (LIMIT),
      .COUNT (COUNT),
      .TICKS (TICKS)
   ) UUT (
      .clk_s_i        (clk_s),
      .reset_i        (reset),
      .ref_i          (ref_clk),
      .sig_i          (sig),
      .axil_req_i     (axil_req),
      .axil_rsp_o     (axil_rsp),
      .sample_o       (sample),
      .sample_valid_o (sample_valid)
   );

   // Antenna level at half-slot h, zero before the first bit
   function automatic logic bit_at(input int ch, input int h);
      if (h < off[ch]) begin
         return 1'b0;
      end
      return bits[ch][(h - off[ch]) / SPAN];
   endfunction

   `include "tb_tasks.svh"

   initial begin : clock_gen
      clk_s = 1'b0;
      forever #20 clk_s = ~clk_s;        // 40 ns period
   end

   // --------------------
   // Antenna and reference drive
   // --------------------
   initial begin : drive_antennas
      ref_clk = 1'b0;
      sig     = '0;
      cyc     = 0;
      forever begin
         @(posedge clk_s);
         #2;
         ref_clk = ((cyc / (RATIO / 2)) % 2) == 1;   // Full period every RATIO clocks
         for (int ch = 0; ch < NCHAN; ch++) begin
            sig[ch].p = bit_at(ch, 2 * cyc);         // Even half-slot first
            sig[ch].n = bit_at(ch, 2 * cyc + 1);
         end
         cyc++;
      end
   end

   initial begin : watchdog
      cycles = 0;
      forever begin
         @(posedge clk_s);
         cycles++;
         if (cycles > MAX_CYCLES) begin
            stop_on_error($sformatf("Timeout: run still going after %0d clock cycles",
                                    MAX_CYCLES));
         end
      end
   end

   // --------------------
   // Test sequence
   // --------------------
   initial begin : run_tests
      void'($urandom(SEED));
      for (int ch = 0; ch < NCHAN; ch++) begin
         for (int k = 0; k < NBITS; k++) begin
            bits[ch][k] = 1'($urandom());
         end
      end
      reset    = 1'b1;
      axil_req = '0;
      repeat (2) @(posedge clk_s);
      #2;
      reset = 1'b0;

      test_registers();
      test_lock();
      test_phase();
      test_lock_loss();
      test_stream();
      test_disable();

      $display("Done: no errors");
      $finish;
   end

endmodule

//--- source/capture_top.sv
`timescale 1ns/10ps

module capture_top
   import capture_pkg::*;
#(
   parameter int NCHAN = 4,        // Antenna channels
   parameter int RATIO = 6,        // Sample clocks per reference period
   parameter int RBITS = 3,        // Period counter width
   parameter int LIMIT = 2,        // Largest accepted delta
   parameter int COUNT = 7,        // Good edges for lock
   parameter int TICKS = 2         // Reference delay stages
) (
   input  logic                  clk_s_i,
   input  logic                  reset_i,
   input  logic                  ref_i,
   input  ddr_pair_t [NCHAN-1:0] sig_i,
   input  axil_req_t             axil_req_i,
   output axil_rsp_t             axil_rsp_o,
   output logic      [NCHAN-1:0] sample_o,
   output logic                  sample_valid_o
);

   ref_tick_t                tick;
   ctrl_cfg_t                cfg;
   chan_status_t [NCHAN-1:0] status;

   // --------------------
   // Shared reference timing
   // --------------------
   ref_timing #(
      .RATIO (RATIO),
      .RBITS (RBITS),
      .TICKS (TICKS)
   ) u_ref_timing (
      .clk_s_i  (clk_s_i),
      .reset_i  (reset_i),
      .ref_i    (ref_i),
      .invert_i (cfg.invert),
      .tick_o   (tick)
   );

   // One tracker per antenna
   for (genvar i = 0; i < NCHAN; i++) begin : g_track
      phase_tracker #(
         .RATIO (RATIO),
         .RBITS (RBITS),
         .LIMIT (LIMIT),
         .COUNT (COUNT)
      ) u_phase_tracker (
         .clk_s_i  (clk_s_i),
         .reset_i  (reset_i),
         .sig_i    (sig_i[i]),
         .tick_i   (tick),
         .enable_i (cfg.enable),
         .retry_i  (cfg.retry),
         .status_o (status[i])
      );
   end

   sample_picker #(
      .NCHAN (NCHAN),
      .RATIO (RATIO),
      .RBITS (RBITS)
   ) u_sample_picker (
      .clk_s_i        (clk_s_i),
      .reset_i        (reset_i),
      .sig_i          (sig_i),
      .tick_i         (tick),
      .status_i       (status),
      .sample_o       (sample_o),
      .sample_valid_o (sample_valid_o)
   );

   // Register block on AXI4-Lite
   capture_ctrl #(
      .NCHAN (NCHAN)
   ) u_capture_ctrl (
      .clk_s_i    (clk_s_i),
      .reset_i    (reset_i),
      .axil_req_i (axil_req_i),
      .axil_rsp_o (axil_rsp_o),
      .status_i   (status),
      .cfg_o      (cfg)
   );

endmodule

//--- source/capture_ctrl.sv
`timescale 1ns/10ps

module capture_ctrl
   import capture_pkg::*;
#(
   parameter int NCHAN = 4
) (
   input  logic                     clk_s_i,
   input  logic                     reset_i,
   input  axil_req_t                axil_req_i,
   output axil_rsp_t                axil_rsp_o,
   input  chan_status_t [NCHAN-1:0] status_i,
   output ctrl_cfg_t                cfg_o
);

   logic              wr_hs;       // AW and W taken together
   logic              rd_hs;
   logic              bvalid_q;
   logic [1:0]        bresp_q;
   logic              rvalid_q;
   logic [1:0]        rresp_q;
   logic [AXI_DW-1:0] rdata_q;
   logic [AXI_DW-1:0] rd_data_w;
   logic              enable_q;
   logic              invert_q;
   logic              retry_q;

   // Status register has room for eight channels
   if (NCHAN > MAX_CHAN) begin : g_chan_check
      $error("capture_ctrl: NCHAN exceeds MAX_CHAN");
   end

   // True for any address in the register map
   function automatic logic addr_mapped(input logic [AXI_AW-1:0] addr);
      logic hit;
      hit = (addr == REG_CTRL) || (addr == REG_STATUS);
      for (int i = 0; i < NCHAN; i++) begin
         if (addr == REG_PHASE0 + AXI_AW'(4 * i)) begin
            hit = 1'b1;
         end
      end
      return hit;
   endfunction

   // No new write while a response is pending
   assign wr_hs = axil_req_i.awvalid & axil_req_i.wvalid & ~bvalid_q;
   assign rd_hs = axil_req_i.arvalid & ~rvalid_q;

   // --------------------
   // Write channel
   // --------------------
   always_ff @(posedge clk_s_i) begin
      if (reset_i) begin
         enable_q <= 1'b0;
         invert_q <= 1'b0;
         retry_q  <= 1'b0;
         bvalid_q <= 1'b0;
         bresp_q  <= RESP_OKAY;
      end else begin
         retry_q <= 1'b0;                          // Pulse lasts one clock
         if (wr_hs) begin
            bvalid_q <= 1'b1;
            bresp_q  <= addr_mapped(axil_req_i.awaddr) ? RESP_OKAY : RESP_SLVERR;
            if (axil_req_i.awaddr == REG_CTRL && axil_req_i.wstrb[0]) begin
               enable_q <= axil_req_i.wdata[0];
               invert_q <= axil_req_i.wdata[1];
               retry_q  <= axil_req_i.wdata[2];
            end
         end else if (bvalid_q && axil_req_i.bready) begin
            bvalid_q <= 1'b0;
         end
      end
   end

   // --------------------
   // Read mux
   // --------------------
   always_comb begin
      rd_data_w = '0;                              // Unmapped reads give zero
      if (axil_req_i.araddr == REG_CTRL) begin
         rd_data_w[0] = enable_q;
         rd_data_w[1] = invert_q;                  // Retry bit stays 0
      end else if (axil_req_i.araddr == REG_STATUS) begin
         for (int i = 0; i < NCHAN; i++) begin
            rd_data_w[i]     = status_i[i].locked;
            rd_data_w[8 + i] = status_i[i].error;
         end
      end else begin
         for (int i = 0; i < NCHAN; i++) begin
            if (axil_req_i.araddr == REG_PHASE0 + AXI_AW'(4 * i)) begin
               rd_data_w[CYC_W:0] = status_i[i].phase;
            end
         end
      end
   end

   // --------------------
   // Read channel
   // --------------------
   always_ff @(posedge clk_s_i) begin
      if (reset_i) begin
         rvalid_q <= 1'b0;
      end else if (rd_hs) begin
         rvalid_q <= 1'b1;
      end else if (rvalid_q && axil_req_i.rready) begin
         rvalid_q <= 1'b0;
      end
   end

   always_ff @(posedge clk_s_i) begin
      if (rd_hs) begin
         rdata_q <= rd_data_w;                     // Sampled at the AR handshake
         rresp_q <= addr_mapped(axil_req_i.araddr) ? RESP_OKAY : RESP_SLVERR;
      end
   end

   assign axil_rsp_o = '{
      awready: wr_hs,
      wready:  wr_hs,
      bresp:   bresp_q,
      bvalid:  bvalid_q,
      arready: ~rvalid_q,
      rdata:   rdata_q,
      rresp:   rresp_q,
      rvalid:  rvalid_q
   };

   assign cfg_o = '{enable: enable_q, invert: invert_q, retry: retry_q};

   // Write response held until the master takes it
   a_bvalid_hold : assert property (@(posedge clk_s_i) disable iff (reset_i)
      bvalid_q && !axil_req_i.bready |=> bvalid_q);

endmodule

//--- capture/sample_picker.sv
`timescale 1ns/10ps

module sample_picker
   import capture_pkg::*;
#(
   parameter int NCHAN = 4,
   parameter int RATIO = 6,
   parameter int RBITS = 3
) (
   input  logic                     clk_s_i,
   input  logic                     reset_i,
   input  ddr_pair_t    [NCHAN-1:0] sig_i,
   input  ref_tick_t                tick_i,
   input  chan_status_t [NCHAN-1:0] status_i,
   output logic         [NCHAN-1:0] sample_o,
   output logic                     sample_valid_o
);

   // Half a bit and a whole bit, in half-cycles
   localparam logic [RBITS+1:0] HALF = (RBITS + 2)'(RATIO);
   localparam logic [RBITS+1:0] SPAN = (RBITS + 2)'(2 * RATIO);

   ddr_pair_t [NCHAN-1:0] sig_q;     // Same alignment as in the trackers
   logic      [NCHAN-1:0] hit_w;     // Mid-bit slot is this clock
   logic      [NCHAN-1:0] pick_w;
   logic      [NCHAN-1:0] held_q;
   logic      [NCHAN-1:0] word_w;

   always_ff @(posedge clk_s_i) begin
      sig_q <= sig_i;
   end

   // --------------------
   // Per-channel slot
   // --------------------
   for (genvar i = 0; i < NCHAN; i++) begin : g_chan
      logic [RBITS+1:0] sum_w;
      logic [RBITS+1:0] slot_w;

      // Phase plus half a bit, modulo one bit
      assign sum_w  = {1'b0, status_i[i].phase} + HALF;
      assign slot_w = (sum_w >= SPAN) ? sum_w - SPAN : sum_w;

      assign hit_w[i]  = (tick_i.cycle == slot_w[RBITS:1]);
      assign pick_w[i] = slot_w[0] ? sig_q[i].n : sig_q[i].p;

      always_ff @(posedge clk_s_i) begin
         if (hit_w[i]) begin
            held_q[i] <= pick_w[i];
         end
      end

      // Slot on the period clock itself goes straight into the word
      assign word_w[i] = status_i[i].locked & (hit_w[i] ? pick_w[i] : held_q[i]);
   end

   // --------------------
   // Word output, no back-pressure
   // --------------------
   always_ff @(posedge clk_s_i) begin
      if (reset_i) begin
         sample_valid_o <= 1'b0;
      end else begin
         sample_valid_o <= tick_i.period;    // One clock after the strobe
      end
   end

   always_ff @(posedge clk_s_i) begin
      if (tick_i.period) begin
         sample_o <= word_w;
      end
   end

endmodule

//--- capture/phase_tracker.sv
`timescale 1ns/10ps

module phase_tracker
   import capture_pkg::*;
#(
   parameter int RATIO = 6,        // Sample clocks per bit
   parameter int RBITS = 3,        // Period counter width
   parameter int LIMIT = 2,        // Largest accepted delta, half-cycles
   parameter int COUNT = 7         // In-bound edges needed for lock
) (
   input  logic         clk_s_i,
   input  logic         reset_i,
   input  ddr_pair_t    sig_i,
   input  ref_tick_t    tick_i,
   input  logic         enable_i,
   input  logic         retry_i,
   output chan_status_t status_o
);

   localparam int CBITS = $clog2(COUNT + 1);
   localparam int DW    = RBITS + 3;     // Room for an unwrapped difference

   localparam logic signed [DW-1:0] RATIO_S = DW'(RATIO);
   localparam logic signed [DW-1:0] SPAN_S  = DW'(2 * RATIO);  // Half-cycles per bit

   ddr_pair_t             sig_q;
   logic                  last_q;        // n half of the pair before sig_q
   logic                  edge_first;
   logic                  edge_second;
   logic                  edge_w;
   logic [RBITS:0]        phase_w;
   logic [RBITS:0]        phase_q;
   logic signed [DW-1:0]  diff_w;
   logic signed [DW-1:0]  wrap_w;
   logic signed [RBITS:0] delta_q;
   logic                  fresh_q;       // Delta was just updated
   logic                  in_bound;
   logic                  lock_lost;
   logic [CBITS-1:0]      count_q;
   logic                  locked_q;
   logic                  error_q;

   // --------------------
   // Input register
   // --------------------
   always_ff @(posedge clk_s_i) begin
      if (reset_i) begin
         sig_q  <= '0;
         last_q <= 1'b0;
      end else begin
         sig_q  <= sig_i;
         last_q <= sig_q.n;
      end
   end

   // Two possible transition spots per clock
   assign edge_first  = last_q ^ sig_q.p;   // Between pairs
   assign edge_second = sig_q.p ^ sig_q.n;  // Inside the pair
   assign edge_w      = edge_first | edge_second;

   // Later transition wins when both are present
   assign phase_w = {tick_i.cycle, edge_second};

   // --------------------
   // Wrapped delta
   // --------------------
   always_comb begin
      diff_w = $signed({2'b00, phase_w}) - $signed({2'b00, phase_q});
      if (diff_w >= RATIO_S) begin
         wrap_w = diff_w - SPAN_S;
      end else if (diff_w < -RATIO_S) begin
         wrap_w = diff_w + SPAN_S;
      end else begin
         wrap_w = diff_w;
      end
   end

   always_ff @(posedge clk_s_i) begin
      if (reset_i) begin
         phase_q <= '0;
         delta_q <= '0;
         fresh_q <= 1'b0;
      end else begin
         fresh_q <= edge_w & enable_i;
         if (edge_w) begin
            phase_q <= phase_w;
            delta_q <= wrap_w[RBITS:0];       // Fits after the wrap
         end
      end
   end

   // --------------------
   // Lock and error
   // --------------------
   assign in_bound  = (delta_q >= -LIMIT) && (delta_q <= LIMIT);
   assign lock_lost = locked_q && fresh_q && !in_bound;

   always_ff @(posedge clk_s_i) begin
      if (reset_i || !enable_i || retry_i) begin
         locked_q <= 1'b0;
         error_q  <= 1'b0;
         count_q  <= '0;
      end else if (lock_lost) begin
         locked_q <= 1'b0;                    // Error replaces lock
         error_q  <= 1'b1;
         count_q  <= '0;
      end else if (!locked_q && !error_q && fresh_q) begin
         if (in_bound) begin
            count_q <= count_q + 1'b1;
            if (count_q == CBITS'(COUNT - 1)) begin
               locked_q <= 1'b1;              // COUNTth good edge
            end
         end else begin
            count_q <= '0;                    // Run broken, start over
         end
      end
   end

   assign status_o = '{phase: phase_q, delta: delta_q, locked: locked_q, error: error_q};

   a_lock_xor_error : assert property (@(posedge clk_s_i) disable iff (reset_i)
      !(locked_q && error_q));

endmodule

//--- capture/ref_timing.sv
`timescale 1ns/10ps

module ref_timing
   import capture_pkg::*;
#(
   parameter int RATIO = 6,        // Sample clocks per reference period
   parameter int RBITS = 3,        // Period counter width
   parameter int TICKS = 2         // Extra delay stages on the reference
) (
   input  logic      clk_s_i,
   input  logic      reset_i,
   input  logic      ref_i,        // Reference clock as a level
   input  logic      invert_i,     // Use falling edges
   output ref_tick_t tick_o
);

   // Two sync flops, TICKS delay flops, one flop of edge history
   localparam int STAGES = TICKS + 3;

   logic [STAGES-1:0] ref_pipe;
   logic              ref_new;
   logic              ref_old;
   logic              edge_w;      // Chosen edge seen at the end of the pipe
   logic              period_q;
   logic              mid_w;
   logic [RBITS-1:0]  cycle_q;

   // Counter width is baked into ref_tick_t
   if (RBITS != CYC_W) begin : g_width_check
      $error("ref_timing: RBITS must match CYC_W of capture_pkg");
   end

   // --------------------
   // Synchroniser and delay line
   // --------------------
   always_ff @(posedge clk_s_i) begin
      if (reset_i) begin
         ref_pipe <= '0;
      end else begin
         ref_pipe <= {ref_pipe[STAGES-2:0], ref_i};  // Shift in at bit 0
      end
   end

   assign ref_new = ref_pipe[STAGES-2];
   assign ref_old = ref_pipe[STAGES-1];

   // Rising by default, falling when inverted
   assign edge_w = invert_i ? (ref_old & ~ref_new) : (~ref_old & ref_new);

   // --------------------
   // Period strobe and counter
   // --------------------
   always_ff @(posedge clk_s_i) begin
      if (reset_i) begin
         period_q <= 1'b0;
         cycle_q  <= '0;
      end else begin
         period_q <= edge_w;
         if (period_q || cycle_q == RBITS'(RATIO - 1)) begin
            cycle_q <= '0;                           // Restart on edge or wrap
         end else begin
            cycle_q <= cycle_q + 1'b1;
         end
      end
   end

   assign mid_w  = (cycle_q == RBITS'(RATIO / 2));
   assign tick_o = '{period: period_q, mid: mid_w, cycle: cycle_q};

   // Counter stays inside one reference period
   a_cycle_range : assert property (@(posedge clk_s_i) disable iff (reset_i)
      cycle_q <= RBITS'(RATIO - 1));

endmodule

//--- common/capture_pkg.sv
package capture_pkg;

   // -------------------
   // Sizes fixed by the struct layouts
   // -------------------
   localparam int CYC_W    = 3;    // Period counter width, modules check RBITS against it
   localparam int MAX_CHAN = 8;    // Status register holds 8 lock and 8 error bits
   localparam int AXI_AW   = 8;
   localparam int AXI_DW   = 32;

   // One channel, two samples per clock
   typedef struct packed {
      logic p;                     // First half of the clock
      logic n;                     // Second half
   } ddr_pair_t;

   typedef struct packed {
      logic             period;    // Start of a reference period
      logic             mid;       // Middle of the period
      logic [CYC_W-1:0] cycle;     // Clock count within the period
   } ref_tick_t;

   typedef struct packed {
      logic        [CYC_W:0] phase;  // Half-cycle units
      logic signed [CYC_W:0] delta;  // Wrapped change of phase
      logic                  locked;
      logic                  error;
   } chan_status_t;

   typedef struct packed {
      logic enable;
      logic invert;                // Falling reference edge
      logic retry;                 // Single-cycle pulse
   } ctrl_cfg_t;

   // -------------------
   // AXI4-Lite
   // -------------------
   typedef struct packed {
      logic [AXI_AW-1:0]   awaddr;
      logic                awvalid;
      logic [AXI_DW-1:0]   wdata;
      logic [AXI_DW/8-1:0] wstrb;
      logic                wvalid;
      logic                bready;
      logic [AXI_AW-1:0]   araddr;
      logic                arvalid;
      logic                rready;
   } axil_req_t;

   typedef struct packed {
      logic              awready;
      logic              wready;
      logic [1:0]        bresp;
      logic              bvalid;
      logic              arready;
      logic [AXI_DW-1:0] rdata;
      logic [1:0]        rresp;
      logic              rvalid;
   } axil_rsp_t;

   // Register map
   localparam logic [AXI_AW-1:0] REG_CTRL   = 8'h00;  // Enable, invert, retry
   localparam logic [AXI_AW-1:0] REG_STATUS = 8'h04;  // Lock 7:0, error 15:8
   localparam logic [AXI_AW-1:0] REG_PHASE0 = 8'h10;  // One word per channel

   localparam logic [1:0] RESP_OKAY   = 2'b00;
   localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage
